// File: common/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register file shape
`define XLEN        32
`define NUM_REGS    32
`define REG_AW      5

// major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

`endif

// File: common/isa_pkg.sv
`include "core_defs.svh"

package isa_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal
    } br_kind_t;

    // second ALU operand
    typedef enum logic {
        op2_reg,
        op2_imm
    } op2_src_t;

    typedef enum logic {
        wb_alu,
        wb_pc4
    } wb_src_t;

    typedef struct packed {
        alu_op_t            alu_op;
        br_kind_t           br;
        op2_src_t           op2_src;
        logic               rf_wen;
        wb_src_t            wb_src;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic               legal;
    } ctrl_t;

endpackage

// File: common/pipe_pkg.sv
`include "core_defs.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef logic [`XLEN-1:0] word_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_resp_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } stage_info_t;

    typedef struct packed {
        logic               valid;
        logic               fwdable;
        logic [`REG_AW-1:0] rd;
        word_t              wdata;
    } fw_entry_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  is_br;
        logic  is_jmp;
        logic  taken;
        word_t target;
    } br_info_t;

    typedef struct packed {
        logic               valid;
        word_t              pc;
        logic               rf_wen;
        logic [`REG_AW-1:0] rd;
        word_t              wdata;
    } commit_t;

    typedef struct packed {
        stage_info_t info;
        ctrl_t       ctrl;
        word_t       imm;
    } ds_payload_t;

    typedef struct packed {
        stage_info_t info;
        ctrl_t       ctrl;
        word_t       imm;
        word_t       op1;
        word_t       op2;
    } exe_payload_t;

    typedef struct packed {
        word_t              pc;
        logic               rf_wen;
        logic [`REG_AW-1:0] rd;
        word_t              wdata;
    } wb_payload_t;

endpackage

// File: source/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     load_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output logic     is_new_o,
    output payload_t data_o
);

    // flush beats hold, no load means a bubble
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_o  <= 1'b0;
            is_new_o <= 1'b0;
        end else if (hold_i) begin
            is_new_o <= 1'b0;
        end else begin
            valid_o  <= load_i && valid_i;
            is_new_o <= load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i && load_i) begin
            data_o <= data_i;
        end
    end

    a_no_new_after_hold: assert property (@(posedge clk) disable iff (reset_i)
        $past(hold_i) |-> !is_new_o);

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

`include "core_defs.svh"

module reg_file (
    input  logic               clk,
    input  logic               reset_i,
    input  logic [`REG_AW-1:0] rs1_i,
    input  logic [`REG_AW-1:0] rs2_i,
    output logic [`XLEN-1:0]   rs1_data_o,
    output logic [`XLEN-1:0]   rs2_data_o,
    input  logic               we_i,
    input  logic [`REG_AW-1:0] rd_i,
    input  logic [`XLEN-1:0]   wdata_i
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

endmodule

// File: core/decoder.sv
`timescale 1ns/1ps

`include "core_defs.svh"

module decoder
    import isa_pkg::*;
(
    input  logic [`XLEN-1:0] inst_i,
    output ctrl_t            ctrl_o,
    output logic [`XLEN-1:0] imm_o
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i_fmt;
    logic [`XLEN-1:0] imm_b_fmt;
    logic [`XLEN-1:0] imm_j_fmt;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    always_comb begin
        ctrl_o       = '0;
        ctrl_o.rd    = inst_i[11:7];
        ctrl_o.legal = 1'b1;
        imm_o        = '0;
        case (opcode)
            `OPC_OP: begin
                ctrl_o.rs1    = inst_i[19:15];
                ctrl_o.rs2    = inst_i[24:20];
                ctrl_o.rf_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl_o.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl_o.alu_op = alu_sub;
                    {7'b0000000, 3'b111}: ctrl_o.alu_op = alu_and;
                    {7'b0000000, 3'b110}: ctrl_o.alu_op = alu_or;
                    {7'b0000000, 3'b100}: ctrl_o.alu_op = alu_xor;
                    default:              ctrl_o.legal  = 1'b0;
                endcase
            end
            `OPC_OPIMM: begin
                ctrl_o.rs1     = inst_i[19:15];
                ctrl_o.op2_src = op2_imm;
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.legal   = funct3 == 3'b000;
                imm_o          = imm_i_fmt;
            end
            `OPC_BRANCH: begin
                ctrl_o.rs1   = inst_i[19:15];
                ctrl_o.rs2   = inst_i[24:20];
                ctrl_o.br    = funct3[0] ? br_bne : br_beq;
                ctrl_o.legal = funct3[2:1] == 2'b00;
                imm_o        = imm_b_fmt;
            end
            `OPC_JAL: begin
                ctrl_o.br     = br_jal;
                ctrl_o.rf_wen = 1'b1;
                ctrl_o.wb_src = wb_pc4;
                imm_o         = imm_j_fmt;
            end
            default: ctrl_o.legal = 1'b0;
        endcase
        // unknown encodings retire as a no-op
        if (!ctrl_o.legal) begin
            ctrl_o = '0;
        end
    end

endmodule

// File: core/operand_select.sv
`timescale 1ns/1ps

`include "core_defs.svh"

module operand_select
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      valid_i,
    input  ctrl_t     ctrl_i,
    input  word_t     imm_i,
    input  word_t     pc_i,
    input  fw_entry_t exe_fw_i,
    input  fw_entry_t wb_fw_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output word_t     op1_o,
    output word_t     op2_o,
    output logic      hazard_o
);

    word_t rs1_val;
    word_t rs2_val;

    // newest producer first, x0 always reads the file
    function automatic word_t pick(input logic [`REG_AW-1:0] rs, input word_t rf_data,
                                   input fw_entry_t exe_fw, input fw_entry_t wb_fw);
        if (rs != '0 && exe_fw.valid && exe_fw.rd == rs) begin
            return exe_fw.wdata;
        end else if (rs != '0 && wb_fw.valid && wb_fw.rd == rs) begin
            return wb_fw.wdata;
        end
        return rf_data;
    endfunction

    function automatic logic blocked(input logic [`REG_AW-1:0] rs, input fw_entry_t exe_fw);
        return rs != '0 && exe_fw.valid && !exe_fw.fwdable && exe_fw.rd == rs;
    endfunction

    always_comb begin
        rs1_val = pick(ctrl_i.rs1, rs1_data_i, exe_fw_i, wb_fw_i);
        rs2_val = pick(ctrl_i.rs2, rs2_data_i, exe_fw_i, wb_fw_i);
        // jal link comes out of the adder as pc + 4
        if (ctrl_i.br == br_jal) begin
            op1_o = pc_i;
            op2_o = `XLEN'd4;
        end else begin
            op1_o = rs1_val;
            op2_o = (ctrl_i.op2_src == op2_imm) ? imm_i : rs2_val;
        end
    end

    assign hazard_o = valid_i && (blocked(ctrl_i.rs1, exe_fw_i) || blocked(ctrl_i.rs2, exe_fw_i));

    a_hazard_needs_valid: assert property (@(posedge clk) disable iff (reset_i)
        !valid_i |-> !hazard_o);

endmodule

// File: core/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      valid_i,
    input  word_t     pc_i,
    input  ctrl_t     ctrl_i,
    input  word_t     imm_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    output word_t     result_o,
    output logic      taken_o,
    output word_t     target_o,
    output fw_entry_t fw_o
);

    logic equal;

    always_comb begin
        case (ctrl_i.alu_op)
            alu_sub: result_o = op1_i - op2_i;
            alu_and: result_o = op1_i & op2_i;
            alu_or:  result_o = op1_i | op2_i;
            alu_xor: result_o = op1_i ^ op2_i;
            default: result_o = op1_i + op2_i;
        endcase
    end

    // branch condition
    assign equal = op1_i == op2_i;

    always_comb begin
        case (ctrl_i.br)
            br_beq:  taken_o = equal;
            br_bne:  taken_o = !equal;
            br_jal:  taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    assign target_o = pc_i + imm_i;

    // only the jal link is ready early enough to forward from here
    assign fw_o = '{valid:   valid_i && ctrl_i.rf_wen,
                    fwdable: ctrl_i.wb_src == wb_pc4,
                    rd:      ctrl_i.rd,
                    wdata:   result_o};

endmodule

// File: core/pipeline_ctrl.sv
`timescale 1ns/1ps

`include "core_defs.svh"

module pipeline_ctrl
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      id_valid_i,
    input  logic      ds_valid_i,
    input  logic      ds_hazard_i,
    input  logic      exe_valid_i,
    input  logic      exe_is_new_i,
    input  word_t     id_pc_i,
    input  word_t     ds_pc_i,
    input  word_t     exe_pc_i,
    input  ctrl_t     exe_ctrl_i,
    input  logic      taken_i,
    input  word_t     target_i,
    output logic      fetch_ready_o,
    output logic      id_hold_o,
    output logic      id_flush_o,
    output logic      ds_hold_o,
    output logic      ds_flush_o,
    output logic      exe_hold_o,
    output logic      exe_bubble_o,
    output redirect_t redirect_o,
    output br_info_t  br_info_o
);

    logic  checked_q;
    logic  unchecked;
    logic  has_succ;
    word_t succ_pc;
    word_t next_pc;
    logic  mispredict;
    logic  ds_stall;

    ////////////////////////////////////////////////////////////////////////////
    // branch check against the next fetched instruction

    assign unchecked  = exe_valid_i && (exe_is_new_i || !checked_q);
    assign has_succ   = id_valid_i || ds_valid_i;
    assign succ_pc    = ds_valid_i ? ds_pc_i : id_pc_i;
    assign next_pc    = taken_i ? target_i : exe_pc_i + `XLEN'd4;
    assign mispredict = unchecked && has_succ && succ_pc != next_pc;

    // a checked instruction must not redirect a second time
    always_ff @(posedge clk) begin
        if (reset_i) begin
            checked_q <= 1'b0;
        end else if (mispredict) begin
            checked_q <= 1'b1;
        end else if (!exe_hold_o) begin
            checked_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stall and flush chain

    // wait for a successor, or keep wrong-path DS out of EXE
    assign exe_hold_o    = (unchecked && !has_succ) || mispredict;
    assign exe_bubble_o  = ds_hazard_i;
    assign ds_stall      = ds_hazard_i || (ds_valid_i && exe_hold_o);
    assign ds_hold_o     = ds_stall;
    assign ds_flush_o    = mispredict;
    assign id_hold_o     = id_valid_i && ds_stall;
    assign id_flush_o    = mispredict || redirect_o.valid;
    assign fetch_ready_o = !id_hold_o;

    ////////////////////////////////////////////////////////////////////////////
    // registered redirect and predictor feedback

    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_o.valid <= 1'b0;
            br_info_o.valid  <= 1'b0;
        end else begin
            redirect_o.valid <= mispredict;
            br_info_o.valid  <= exe_valid_i && exe_is_new_i && exe_ctrl_i.br != br_none;
        end
        redirect_o.target <= next_pc;
        br_info_o.pc      <= exe_pc_i;
        br_info_o.is_br   <= exe_ctrl_i.br == br_beq || exe_ctrl_i.br == br_bne;
        br_info_o.is_jmp  <= exe_ctrl_i.br == br_jal;
        br_info_o.taken   <= taken_i;
        br_info_o.target  <= target_i;
    end

    a_single_redirect: assert property (@(posedge clk) disable iff (reset_i)
        redirect_o.valid |=> !redirect_o.valid);

endmodule

// File: core/core_top.sv
`timescale 1ns/1ps

module core_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        fetch_valid_i,
    input  fetch_resp_t fetch_resp_i,
    output logic        fetch_ready_o,
    output redirect_t   redirect_o,
    output br_info_t    br_info_o,
    output commit_t     commit_o
);

    // ID
    stage_info_t  fetch_info;
    stage_info_t  id_q;
    logic         id_valid;
    logic         id_hold;
    logic         id_flush;
    ctrl_t        id_ctrl;
    word_t        id_imm;
    // DS
    ds_payload_t  ds_in;
    ds_payload_t  ds_q;
    logic         ds_valid;
    logic         ds_hold;
    logic         ds_flush;
    logic         ds_hazard;
    word_t        ds_op1;
    word_t        ds_op2;
    word_t        rs1_data;
    word_t        rs2_data;
    // EXE
    exe_payload_t exe_in;
    exe_payload_t exe_q;
    logic         exe_valid;
    logic         exe_is_new;
    logic         exe_hold;
    logic         exe_bubble;
    word_t        exe_result;
    logic         exe_taken;
    word_t        exe_target;
    fw_entry_t    exe_fw;
    // WB
    wb_payload_t  wb_in;
    wb_payload_t  wb_q;
    logic         wb_valid;
    fw_entry_t    wb_fw;

    assign fetch_info = '{pc: fetch_resp_i.pc, inst: fetch_resp_i.inst};
    assign ds_in      = '{info: id_q, ctrl: id_ctrl, imm: id_imm};
    assign exe_in     = '{info: ds_q.info, ctrl: ds_q.ctrl, imm: ds_q.imm, op1: ds_op1, op2: ds_op2};
    assign wb_in      = '{pc: exe_q.info.pc, rf_wen: exe_q.ctrl.rf_wen, rd: exe_q.ctrl.rd,
                          wdata: exe_result};
    assign wb_fw      = '{valid: wb_valid && wb_q.rf_wen, fwdable: 1'b1, rd: wb_q.rd,
                          wdata: wb_q.wdata};
    assign commit_o   = '{valid: wb_valid, pc: wb_q.pc, rf_wen: wb_q.rf_wen, rd: wb_q.rd,
                          wdata: wb_q.wdata};

    stage_reg #(.payload_t(stage_info_t)) u_id_reg (
        .clk(clk), .reset_i(reset_i),
        .load_i(1'b1), .hold_i(id_hold), .flush_i(id_flush),
        .valid_i(fetch_valid_i), .data_i(fetch_info),
        .valid_o(id_valid), .is_new_o(), .data_o(id_q)
    );

    decoder u_decoder (
        .inst_i(id_q.inst), .ctrl_o(id_ctrl), .imm_o(id_imm)
    );

    stage_reg #(.payload_t(ds_payload_t)) u_ds_reg (
        .clk(clk), .reset_i(reset_i),
        .load_i(1'b1), .hold_i(ds_hold), .flush_i(ds_flush),
        .valid_i(id_valid), .data_i(ds_in),
        .valid_o(ds_valid), .is_new_o(), .data_o(ds_q)
    );

    operand_select u_operand_select (
        .clk(clk), .reset_i(reset_i),
        .valid_i(ds_valid), .ctrl_i(ds_q.ctrl), .imm_i(ds_q.imm), .pc_i(ds_q.info.pc),
        .exe_fw_i(exe_fw), .wb_fw_i(wb_fw),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .op1_o(ds_op1), .op2_o(ds_op2), .hazard_o(ds_hazard)
    );

    stage_reg #(.payload_t(exe_payload_t)) u_exe_reg (
        .clk(clk), .reset_i(reset_i),
        .load_i(!exe_bubble), .hold_i(exe_hold), .flush_i(1'b0),
        .valid_i(ds_valid), .data_i(exe_in),
        .valid_o(exe_valid), .is_new_o(exe_is_new), .data_o(exe_q)
    );

    execute_stage u_execute (
        .valid_i(exe_valid), .pc_i(exe_q.info.pc), .ctrl_i(exe_q.ctrl), .imm_i(exe_q.imm),
        .op1_i(exe_q.op1), .op2_i(exe_q.op2),
        .result_o(exe_result), .taken_o(exe_taken), .target_o(exe_target), .fw_o(exe_fw)
    );

    pipeline_ctrl u_ctrl (
        .clk(clk), .reset_i(reset_i),
        .id_valid_i(id_valid), .ds_valid_i(ds_valid), .ds_hazard_i(ds_hazard),
        .exe_valid_i(exe_valid), .exe_is_new_i(exe_is_new),
        .id_pc_i(id_q.pc), .ds_pc_i(ds_q.info.pc), .exe_pc_i(exe_q.info.pc),
        .exe_ctrl_i(exe_q.ctrl), .taken_i(exe_taken), .target_i(exe_target),
        .fetch_ready_o(fetch_ready_o),
        .id_hold_o(id_hold), .id_flush_o(id_flush),
        .ds_hold_o(ds_hold), .ds_flush_o(ds_flush),
        .exe_hold_o(exe_hold), .exe_bubble_o(exe_bubble),
        .redirect_o(redirect_o), .br_info_o(br_info_o)
    );

    // WB never stalls, a held EXE sends it a bubble
    stage_reg #(.payload_t(wb_payload_t)) u_wb_reg (
        .clk(clk), .reset_i(reset_i),
        .load_i(!exe_hold), .hold_i(1'b0), .flush_i(1'b0),
        .valid_i(exe_valid), .data_i(wb_in),
        .valid_o(wb_valid), .is_new_o(), .data_o(wb_q)
    );

    reg_file u_reg_file (
        .clk(clk), .reset_i(reset_i),
        .rs1_i(ds_q.ctrl.rs1), .rs2_i(ds_q.ctrl.rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(wb_valid && wb_q.rf_wen), .rd_i(wb_q.rd), .wdata_i(wb_q.wdata)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0) clk = ~clk;
        end
    end

endmodule

// File: tests/tb_core.sv
`timescale 1ns/1ps

module tb_core
    import pipe_pkg::*;
();

    localparam int          PROG_LEN       = 200;
    localparam logic [31:0] END_PC         = 32'(PROG_LEN * 4);
    localparam logic [31:0] SEED           = 32'h3728068d;
    localparam logic [31:0] NOP            = 32'h00000013;
    localparam int          TIMEOUT_CYCLES = 16 + PROG_LEN * 20;

    logic        clk;
    logic        reset_i;
    logic        fetch_valid_i;
    fetch_resp_t fetch_resp_i;
    logic        fetch_ready_o;
    redirect_t   redirect_o;
    br_info_t    br_info_o;
    commit_t     commit_o;

    // program: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 addi, 6 beq, 7 bne, 8 jal
    logic [31:0] prog_word [PROG_LEN];
    int          prog_kind [PROG_LEN];
    logic [4:0]  prog_rd   [PROG_LEN];
    logic [4:0]  prog_rs1  [PROG_LEN];
    logic [4:0]  prog_rs2  [PROG_LEN];
    logic [31:0] prog_imm  [PROG_LEN];

    // expected traffic from the reference model
    logic [31:0] exp_pc [$];
    logic        exp_wen [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_wdata [$];
    logic [31:0] exp_br_pc [$];
    logic        exp_br_taken [$];
    logic [31:0] exp_br_target [$];
    logic        exp_br_jmp [$];
    logic [31:0] exp_redirect [$];

    logic [31:0] rng;
    logic [31:0] fetch_pc;
    logic        accept_pending;
    logic        first_fetch;
    logic        fetch_en;
    logic        mon_en;
    int          errors;
    int          n_expected;
    int          n_commits;
    int          n_redirects;
    int          n_br_infos;

    tb_clock #(.PERIOD(8.0)) u_clock (.clk(clk));

    core_top uut (
        .clk(clk), .reset_i(reset_i),
        .fetch_valid_i(fetch_valid_i), .fetch_resp_i(fetch_resp_i),
        .fetch_ready_o(fetch_ready_o), .redirect_o(redirect_o),
        .br_info_o(br_info_o), .commit_o(commit_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] pc);
        if (pc < END_PC) begin
            return prog_word[pc[9:2]];
        end
        return NOP;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // random program and reference model

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] off;
        logic [6:0]  f7;
        logic [2:0]  f3;
        for (int i = 0; i < PROG_LEN; i++) begin
            r = draw();
            prog_kind[i] = int'(r % 32'd9);
            r = draw();
            prog_rd[i]  = {2'b00, r[2:0]};
            prog_rs1[i] = {2'b00, r[5:3]};
            prog_rs2[i] = {2'b00, r[8:6]};
            off = (32'd2 + (draw() % 32'd5)) << 2;
            r = draw();
            f7 = (prog_kind[i] == 1) ? 7'b0100000 : 7'b0000000;
            case (prog_kind[i])
                2:       f3 = 3'b111;
                3:       f3 = 3'b110;
                4:       f3 = 3'b100;
                default: f3 = 3'b000;
            endcase
            if (prog_kind[i] <= 4) begin
                prog_imm[i]  = '0;
                prog_word[i] = {f7, prog_rs2[i], prog_rs1[i], f3, prog_rd[i], 7'b0110011};
            end else if (prog_kind[i] == 5) begin
                prog_imm[i]  = {{20{r[11]}}, r[11:0]};
                prog_word[i] = {r[11:0], prog_rs1[i], 3'b000, prog_rd[i], 7'b0010011};
            end else if (prog_kind[i] <= 7) begin
                prog_imm[i]  = off;
                f3           = (prog_kind[i] == 7) ? 3'b001 : 3'b000;
                prog_word[i] = {off[12], off[10:5], prog_rs2[i], prog_rs1[i], f3,
                                off[4:1], off[11], 7'b1100011};
            end else begin
                prog_imm[i]  = off;
                prog_word[i] = {off[20], off[10:1], off[11], off[19:12], prog_rd[i],
                                7'b1101111};
            end
        end
    endtask

    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        taken;
        int          k;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        while (pc < END_PC) begin
            k = prog_kind[pc[9:2]];
            a = regs[prog_rs1[pc[9:2]]];
            b = regs[prog_rs2[pc[9:2]]];
            taken = 1'b0;
            case (k)
                0:       res = a + b;
                1:       res = a - b;
                2:       res = a & b;
                3:       res = a | b;
                4:       res = a ^ b;
                5:       res = a + prog_imm[pc[9:2]];
                6:       res = '0;
                7:       res = '0;
                default: res = pc + 32'd4;
            endcase
            if (k == 6) taken = a == b;
            if (k == 7) taken = a != b;
            if (k == 8) taken = 1'b1;
            exp_pc.push_back(pc);
            exp_wen.push_back(k <= 5 || k == 8);
            exp_rd.push_back(prog_rd[pc[9:2]]);
            exp_wdata.push_back(res);
            if ((k <= 5 || k == 8) && prog_rd[pc[9:2]] != 5'd0) begin
                regs[prog_rd[pc[9:2]]] = res;
            end
            if (k >= 6) begin
                exp_br_pc.push_back(pc);
                exp_br_taken.push_back(taken);
                exp_br_target.push_back(pc + prog_imm[pc[9:2]]);
                exp_br_jmp.push_back(k == 8);
            end
            // sequential fetch always misses a taken branch or jal
            if (taken) begin
                exp_redirect.push_back(pc + prog_imm[pc[9:2]]);
                pc = pc + prog_imm[pc[9:2]];
            end else begin
                pc = pc + 32'd4;
            end
        end
        n_expected = exp_pc.size();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // fetch model

    always @(negedge clk) begin
        logic [31:0] r;
        if (!fetch_en) begin
            fetch_valid_i = 1'b0;
        end else begin
            if (accept_pending) begin
                fetch_pc = fetch_pc + 32'd4;
            end
            if (redirect_o.valid) begin
                fetch_pc      = redirect_o.target;
                fetch_valid_i = 1'b0;
            end else if (!fetch_valid_i || accept_pending) begin
                r = draw();
                fetch_valid_i = r[1:0] != 2'b00;
                fetch_resp_i  = '{pc: fetch_pc, inst: fetch_word(fetch_pc)};
            end
            // ready depends only on pipeline state, so it holds until the edge
            accept_pending = fetch_valid_i && fetch_ready_o;
        end
    end

    // first response taken by the core
    always @(posedge clk) begin
        if (fetch_valid_i && fetch_ready_o) begin
            first_fetch = 1'b1;
        end
    end

    // output monitors
    always @(negedge clk) begin
        if (mon_en) begin
            if (!first_fetch && (commit_o.valid || redirect_o.valid || br_info_o.valid)) begin
                $display("ERROR: output valid before the first fetch was accepted");
                errors++;
            end
            if (commit_o.valid && commit_o.pc < END_PC) begin
                if (exp_pc.size() == 0) begin
                    $display("ERROR: commit at pc %h that the program never retires",
                             commit_o.pc);
                    errors++;
                end else begin
                    check_value("commit pc", exp_pc.pop_front(), commit_o.pc);
                    check_value("commit wen", 32'(exp_wen[0]), 32'(commit_o.rf_wen));
                    if (exp_wen.pop_front()) begin
                        check_value("commit rd", 32'(exp_rd[0]), 32'(commit_o.rd));
                        check_value("commit wdata", exp_wdata[0], commit_o.wdata);
                    end
                    void'(exp_rd.pop_front());
                    void'(exp_wdata.pop_front());
                    n_commits++;
                end
            end
            if (redirect_o.valid) begin
                n_redirects++;
                if (exp_redirect.size() == 0) begin
                    $display("ERROR: redirect to %h with no taken branch", redirect_o.target);
                    errors++;
                end else begin
                    check_value("redirect target", exp_redirect.pop_front(), redirect_o.target);
                end
            end
            if (br_info_o.valid) begin
                n_br_infos++;
                if (exp_br_pc.size() == 0) begin
                    $display("ERROR: branch info for pc %h with no branch left", br_info_o.pc);
                    errors++;
                end else begin
                    check_value("br_info pc", exp_br_pc.pop_front(), br_info_o.pc);
                    check_value("br_info taken", 32'(exp_br_taken.pop_front()),
                                32'(br_info_o.taken));
                    check_value("br_info target", exp_br_target.pop_front(), br_info_o.target);
                    check_value("br_info is_br", 32'(!exp_br_jmp[0]), 32'(br_info_o.is_br));
                    check_value("br_info is_jmp", 32'(exp_br_jmp.pop_front()),
                                32'(br_info_o.is_jmp));
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles with %0d of %0d commits",
                 TIMEOUT_CYCLES, n_commits, n_expected);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rng            = SEED;
        reset_i        = 1'b1;
        fetch_valid_i  = 1'b0;
        fetch_resp_i   = '0;
        fetch_pc       = '0;
        accept_pending = 1'b0;
        first_fetch    = 1'b0;
        fetch_en       = 1'b0;
        mon_en         = 1'b0;
        errors         = 0;
        n_commits      = 0;
        n_redirects    = 0;
        n_br_infos     = 0;
        build_program();
        run_model();
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        mon_en  = 1'b1;
        // idle a while to see the outputs stay quiet
        repeat (5) @(negedge clk);
        fetch_en = 1'b1;
        while (n_commits < n_expected) begin
            @(negedge clk);
        end
        repeat (30) @(negedge clk);
        if (exp_redirect.size() != 0 || exp_br_pc.size() != 0) begin
            $display("ERROR: %0d redirects and %0d branch infos never appeared",
                     exp_redirect.size(), exp_br_pc.size());
            errors++;
        end
        $display("commits %0d of %0d, redirects %0d, branch infos %0d, errors %0d",
                 n_commits, n_expected, n_redirects, n_br_infos, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
source/stage_reg.sv
source/reg_file.sv
core/decoder.sv
core/operand_select.sv
core/execute_stage.sv
core/pipeline_ctrl.sv
core/core_top.sv
tests/tb_clock.sv
tests/tb_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the simulation"
	@echo "make clean  remove build output and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_core -f sim.f -Mdir obj_dir -o sim_core
	-./obj_dir/sim_core > sim.log 2>&1
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
